// ==== rtl/soc_mem_pkg.sv ====
package soc_mem_pkg;

	// instruction region, word aligned from address zero
	localparam int INST_WORDS = 16;
	localparam int INST_AW = $clog2(INST_WORDS);
	localparam logic [31:0] INST_END = 32'(INST_WORDS * 4 - 4);

	// data region follows the last instruction word
	localparam logic [31:0] DATA_BASE = INST_END + 32'd4;
	localparam int DATA_WORDS = 64;
	localparam int DATA_AW = $clog2(DATA_WORDS);
	localparam logic [31:0] DATA_END = DATA_BASE + 32'(4 * DATA_WORDS);

	localparam int TRACE_FIFO_DEPTH = 8;
	localparam int CLKS_PER_BIT = 4;
	localparam string ROM_IMAGE = "rtl/inst_rom.hex";

	typedef logic [INST_AW-1:0] rom_idx_t;
	typedef logic [DATA_AW-1:0] ram_idx_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic        we;
	} mem_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic        err;
	} mem_resp_t;

	typedef logic [7:0] trace_byte_t;

endpackage

// ==== rtl/mem_router.sv ====
module mem_router (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  req_i,
	input  soc_mem_pkg::mem_req_t  cpu_req_i,
	output logic                  ack_o,
	output soc_mem_pkg::mem_resp_t cpu_resp_o,
	output logic                  rom_rd_o,
	output soc_mem_pkg::rom_idx_t  rom_addr_o,
	input  logic [31:0]           rom_data_i,
	output logic                  ram_rd_o,
	output logic                  ram_wr_o,
	output soc_mem_pkg::ram_idx_t  ram_addr_o,
	output logic [31:0]           ram_wdata_o,
	output logic [3:0]            ram_strb_o,
	input  logic [31:0]           ram_data_i,
	output logic                  fetch_valid_o,
	output logic [31:0]           fetch_word_o,
	input  logic                  trace_ready_i
);
	import soc_mem_pkg::*;

	typedef enum logic [2:0] {S_IDLE, S_ACCESS, S_WAIT_TRACE, S_ACK, S_RELEASE} state_t;
	typedef enum logic [1:0] {K_ROM, K_RAM_RD, K_RAM_WR, K_ERR} kind_t;

	state_t state_q;
	kind_t kind_q;
	kind_t kind_d;
	mem_req_t req_q;
	mem_resp_t resp_q;
	logic [31:0] ram_off;

	// region decode on the incoming request
	always_comb begin
		if (cpu_req_i.addr <= INST_END) begin
			kind_d = cpu_req_i.we ? K_ERR : K_ROM;
		end else if (cpu_req_i.addr >= DATA_BASE && cpu_req_i.addr < DATA_END) begin
			kind_d = cpu_req_i.we ? K_RAM_WR : K_RAM_RD;
		end else begin
			kind_d = K_ERR;
		end
	end

	assign ram_off = req_q.addr - DATA_BASE;

	assign rom_rd_o = (state_q == S_ACCESS) && (kind_q == K_ROM);
	assign ram_rd_o = (state_q == S_ACCESS) && (kind_q == K_RAM_RD);
	assign ram_wr_o = (state_q == S_ACCESS) && (kind_q == K_RAM_WR);
	assign rom_addr_o = req_q.addr[INST_AW+1:2];
	assign ram_addr_o = ram_off[DATA_AW+1:2];
	assign ram_wdata_o = req_q.wdata;
	assign ram_strb_o = req_q.strb;

	// fetch goes to the tracer in the same edge the response is latched
	assign fetch_valid_o = (state_q == S_WAIT_TRACE) && (kind_q == K_ROM) && trace_ready_i;
	assign fetch_word_o = rom_data_i;

	assign ack_o = (state_q == S_ACK) || (state_q == S_RELEASE);
	assign cpu_resp_o = resp_q;

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state_q <= S_IDLE;
			kind_q <= K_ERR;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (req_i) begin
						state_q <= S_ACCESS;
						kind_q <= kind_d;
					end
				end
				S_ACCESS: state_q <= S_WAIT_TRACE;
				S_WAIT_TRACE: begin
					if (kind_q != K_ROM || trace_ready_i) begin
						state_q <= S_ACK;
					end
				end
				S_ACK: begin
					if (!req_i) begin
						state_q <= S_RELEASE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (state_q == S_IDLE && req_i) begin
			req_q <= cpu_req_i;
		end
		if (state_q == S_WAIT_TRACE) begin
			resp_q.err <= (kind_q == K_ERR);
			case (kind_q)
				K_ROM: resp_q.rdata <= rom_data_i;
				K_RAM_RD: resp_q.rdata <= ram_data_i;
				default: resp_q.rdata <= 32'h0;
			endcase
		end
	end

	// requester must still hold req when ack comes up
	a_ack_needs_req: assert property (@(posedge clk_cpu) disable iff (rst)
		$rose(ack_o) |-> req_i);

endmodule

// ==== rtl/inst_rom.sv ====
module inst_rom (
	input  logic                 clk_cpu,
	input  logic                 rom_rd_i,
	input  soc_mem_pkg::rom_idx_t rom_addr_i,
	output logic [31:0]          rom_data_o
);
	import soc_mem_pkg::*;

	logic [31:0] mem [INST_WORDS];

	// program image, fixed after load
	initial begin
		$readmemh(ROM_IMAGE, mem);
	end

	always_ff @(posedge clk_cpu) begin
		if (rom_rd_i) begin
			rom_data_o <= mem[rom_addr_i];
		end
	end

endmodule

// ==== rtl/data_ram.sv ====
module data_ram (
	input  logic                 clk_cpu,
	input  logic                 ram_rd_i,
	input  logic                 ram_wr_i,
	input  soc_mem_pkg::ram_idx_t ram_addr_i,
	input  logic [31:0]          ram_wdata_i,
	input  logic [3:0]           ram_strb_i,
	output logic [31:0]          ram_data_o
);
	import soc_mem_pkg::*;

	logic [31:0] mem [DATA_WORDS];

	// unwritten words read back as zero
	initial begin
		for (int i = 0; i < DATA_WORDS; i++) begin
			mem[i] = 32'h0;
		end
	end

	// byte lanes follow the strobe bits
	always_ff @(posedge clk_cpu) begin
		if (ram_wr_i) begin
			for (int b = 0; b < 4; b++) begin
				if (ram_strb_i[b]) begin
					mem[ram_addr_i][8*b +: 8] <= ram_wdata_i[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (ram_rd_i) begin
			ram_data_o <= mem[ram_addr_i];
		end
	end

endmodule

// ==== rtl/fetch_tracer.sv ====
module fetch_tracer (
	input  logic                    clk_cpu,
	input  logic                    rst,
	input  logic                    fetch_valid_i,
	input  logic [31:0]             fetch_word_i,
	output logic                    trace_ready_o,
	output logic                    push_o,
	output soc_mem_pkg::trace_byte_t push_data_o,
	input  logic                    full_i
);
	import soc_mem_pkg::*;

	logic busy_q;
	logic [1:0] cnt_q;
	logic [31:0] word_q;

	assign trace_ready_o = !busy_q;
	assign push_o = busy_q && !full_i;
	assign push_data_o = trace_byte_t'(word_q[7:0]);

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			busy_q <= 1'b0;
			cnt_q <= 2'd0;
		end else if (fetch_valid_i) begin
			busy_q <= 1'b1;
			cnt_q <= 2'd0;
		end else if (push_o) begin
			cnt_q <= cnt_q + 2'd1;
			// holder frees up after byte 3
			if (cnt_q == 2'd3) begin
				busy_q <= 1'b0;
			end
		end
	end

	// low byte goes out first, then shift down
	always_ff @(posedge clk_cpu) begin
		if (fetch_valid_i) begin
			word_q <= fetch_word_i;
		end else if (push_o) begin
			word_q <= {8'h00, word_q[31:8]};
		end
	end

	// router may only hand over into an empty holder
	a_fetch_when_ready: assert property (@(posedge clk_cpu) disable iff (rst)
		fetch_valid_i |-> trace_ready_o);

endmodule

// ==== rtl/sync_fifo.sv ====
module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk_cpu,
	input  logic     rst,
	input  logic     push_i,
	input  payload_t push_data_i,
	output logic     full_o,
	input  logic     pop_i,
	output payload_t pop_data_o,
	output logic     empty_o
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic [CW-1:0] count_q;
	logic do_push;
	logic do_pop;

	assign full_o = (count_q == CW'(DEPTH));
	assign empty_o = (count_q == '0);
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;
	assign pop_data_o = mem[rd_ptr_q];

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (do_pop) begin
				rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			count_q <= count_q + CW'(do_push) - CW'(do_pop);
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (do_push) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	a_no_pop_empty: assert property (@(posedge clk_cpu) disable iff (rst)
		pop_i |-> !empty_o);

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx (
	input  logic                    clk_cpu,
	input  logic                    rst,
	input  logic                    empty_i,
	input  soc_mem_pkg::trace_byte_t data_i,
	output logic                    pop_o,
	output logic                    tx_o
);
	import soc_mem_pkg::*;

	localparam int TW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

	logic busy_q;
	logic [9:0] shreg_q;
	logic [TW-1:0] tick_q;
	logic [3:0] bit_q;
	logic bit_end;
	logic frame_end;

	assign bit_end = (tick_q == TW'(CLKS_PER_BIT - 1));
	// last cycle of the stop bit
	assign frame_end = busy_q && bit_end && (bit_q == 4'd9);

	// take the next byte so frames run back to back
	assign pop_o = !empty_i && (!busy_q || frame_end);
	assign tx_o = shreg_q[0];

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			busy_q <= 1'b0;
			shreg_q <= '1;
			tick_q <= '0;
			bit_q <= 4'd0;
		end else if (pop_o) begin
			busy_q <= 1'b1;
			// stop, data lsb first, start
			shreg_q <= {1'b1, data_i, 1'b0};
			tick_q <= '0;
			bit_q <= 4'd0;
		end else if (busy_q) begin
			if (bit_end) begin
				tick_q <= '0;
				shreg_q <= {1'b1, shreg_q[9:1]};
				bit_q <= bit_q + 4'd1;
				if (bit_q == 4'd9) begin
					busy_q <= 1'b0;
				end
			end else begin
				tick_q <= tick_q + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/mem_subsys_top.sv ====
module mem_subsys_top (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  req_i,
	input  soc_mem_pkg::mem_req_t  cpu_req_i,
	output logic                  ack_o,
	output soc_mem_pkg::mem_resp_t cpu_resp_o,
	output logic                  tx_o
);
	import soc_mem_pkg::*;

	logic rom_rd;
	rom_idx_t rom_addr;
	logic [31:0] rom_data;
	logic ram_rd;
	logic ram_wr;
	ram_idx_t ram_addr;
	logic [31:0] ram_wdata;
	logic [3:0] ram_strb;
	logic [31:0] ram_data;
	logic fetch_valid;
	logic [31:0] fetch_word;
	logic trace_ready;
	logic push;
	trace_byte_t push_data;
	logic full;
	logic pop;
	trace_byte_t pop_data;
	logic empty;

	mem_router u_router (
		.clk_cpu(clk_cpu), .rst(rst), .req_i(req_i), .cpu_req_i(cpu_req_i),
		.ack_o(ack_o), .cpu_resp_o(cpu_resp_o),
		.rom_rd_o(rom_rd), .rom_addr_o(rom_addr), .rom_data_i(rom_data),
		.ram_rd_o(ram_rd), .ram_wr_o(ram_wr), .ram_addr_o(ram_addr),
		.ram_wdata_o(ram_wdata), .ram_strb_o(ram_strb), .ram_data_i(ram_data),
		.fetch_valid_o(fetch_valid), .fetch_word_o(fetch_word),
		.trace_ready_i(trace_ready)
	);

	inst_rom u_inst_rom (
		.clk_cpu(clk_cpu), .rom_rd_i(rom_rd), .rom_addr_i(rom_addr),
		.rom_data_o(rom_data)
	);

	data_ram u_data_ram (
		.clk_cpu(clk_cpu), .ram_rd_i(ram_rd), .ram_wr_i(ram_wr),
		.ram_addr_i(ram_addr), .ram_wdata_i(ram_wdata), .ram_strb_i(ram_strb),
		.ram_data_o(ram_data)
	);

	// fetch trace path: bytes, queue, serial line
	fetch_tracer u_tracer (
		.clk_cpu(clk_cpu), .rst(rst), .fetch_valid_i(fetch_valid),
		.fetch_word_i(fetch_word), .trace_ready_o(trace_ready),
		.push_o(push), .push_data_o(push_data), .full_i(full)
	);

	sync_fifo #(
		.payload_t(trace_byte_t),
		.DEPTH(TRACE_FIFO_DEPTH)
	) u_fifo (
		.clk_cpu(clk_cpu), .rst(rst), .push_i(push), .push_data_i(push_data),
		.full_o(full), .pop_i(pop), .pop_data_o(pop_data), .empty_o(empty)
	);

	uart_tx u_tx (
		.clk_cpu(clk_cpu), .rst(rst), .empty_i(empty), .data_i(pop_data),
		.pop_o(pop), .tx_o(tx_o)
	);

endmodule

// ==== dv/tb_mem_subsys.sv ====
module tb_mem_subsys;
	timeunit 1ns;
	timeprecision 100ps;
	import soc_mem_pkg::*;

	typedef enum logic [3:0] {OP_RD = 4'h0, OP_WR = 4'h1, OP_TRACE = 4'h3, OP_END = 4'hf} golden_op_t;

	// one row of the golden file
	typedef struct packed {
		logic [3:0]  op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [31:0] rdata;
		logic [3:0]  err;
	} golden_rec_t;

	logic clk_cpu;
	logic rst;
	logic req;
	mem_req_t cpu_req;
	logic ack;
	mem_resp_t cpu_resp;
	logic tx;

	logic [107:0] golden_raw [64];
	golden_rec_t accesses[$];
	trace_byte_t exp_bytes[$];
	logic [31:0] lfsr_q;
	int cycle_limit;
	int cycles;
	int rx_count;
	int n_trace;
	int stall_count;

	mem_subsys_top i_dut (
		.clk_cpu(clk_cpu),
		.rst(rst),
		.req_i(req),
		.cpu_req_i(cpu_req),
		.ack_o(ack),
		.cpu_resp_o(cpu_resp),
		.tx_o(tx)
	);

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_resp(input string name, input mem_resp_t exp_resp, input mem_resp_t act);
		if (act !== exp_resp) begin
			$display("ERR %s expected rdata=%h err=%h actual rdata=%h err=%h",
				name, exp_resp.rdata, exp_resp.err, act.rdata, act.err);
			abort_run();
		end
	endtask

	task automatic compare_trace_byte(input string name, input trace_byte_t exp_b,
		input trace_byte_t act);
		if (act !== exp_b) begin
			$display("ERR %s expected %h actual %h", name, exp_b, act);
			abort_run();
		end
	endtask

	task automatic expect_level(input string name, input logic exp_l, input logic act);
		if (act !== exp_l) begin
			$display("ERR %s expected %h actual %h", name, exp_l, act);
			abort_run();
		end
	endtask

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		lfsr_step = {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic draw_gap(output int n);
		n = 0;
		for (int i = 0; i < 3; i++) begin
			n = (n << 1) | int'(lfsr_q[0]);
			lfsr_q = lfsr_step(lfsr_q);
		end
	endtask

	task automatic load_golden();
		golden_rec_t rec;
		$readmemh("dv/mem_golden.txt", golden_raw);
		n_trace = 0;
		for (int i = 0; i < 64; i++) begin
			rec = golden_rec_t'(golden_raw[i]);
			if ($isunknown(rec.op) || rec.op == OP_END) begin
				break;
			end
			if (rec.op == OP_TRACE) begin
				// leftmost byte of the row goes out first
				for (int b = 3; b >= 0; b--) begin
					exp_bytes.push_back(rec.rdata[8*b +: 8]);
				end
				n_trace += 4;
			end else begin
				accesses.push_back(rec);
			end
		end
		if (accesses.size() == 0 || n_trace == 0) begin
			$display("golden file dv/mem_golden.txt holds no accesses or no trace bytes");
			abort_run();
		end
	endtask

	task automatic run_access(input golden_rec_t rec);
		mem_req_t r;
		mem_resp_t exp_resp;
		logic fetch;
		int waited;
		r.addr = rec.addr;
		r.wdata = rec.wdata;
		r.strb = rec.strb;
		r.we = (rec.op == OP_WR);
		exp_resp.rdata = rec.rdata;
		exp_resp.err = rec.err[0];
		fetch = (rec.op == OP_RD) && !rec.err[0] && (rec.addr <= INST_END);
		waited = 0;
		@(posedge clk_cpu);
		req <= 1'b1;
		cpu_req <= r;
		@(negedge clk_cpu);
		expect_level("ack_o before req_i sampled", 1'b0, ack);
		while (!ack) begin
			@(negedge clk_cpu);
			waited++;
		end
		// registered at k, ack after k+2; fetches may stall on trace back-pressure
		if (fetch ? (waited < 3) : (waited != 3)) begin
			$display("ack_o came %0d cycles after the request to address %h", waited, rec.addr);
			abort_run();
		end
		if (fetch && waited > 3) begin
			stall_count++;
		end
		check_resp($sformatf("cpu_resp_o at %h", rec.addr), exp_resp, cpu_resp);
		@(posedge clk_cpu);
		req <= 1'b0;
		@(negedge clk_cpu);
		expect_level("ack_o before req_i low sampled", 1'b1, ack);
		@(negedge clk_cpu);
		expect_level("ack_o in release cycle", 1'b1, ack);
		@(negedge clk_cpu);
		expect_level("ack_o after release", 1'b0, ack);
	endtask

	initial begin : clock_gen
		clk_cpu = 1'b0;
		forever begin
			#10 clk_cpu = ~clk_cpu;
		end
	end

	initial begin : cpu_model
		int gap;
		rst = 1'b1;
		req = 1'b0;
		cpu_req = '0;
		lfsr_q = 32'hb65c_8dcc;
		stall_count = 0;
		load_golden();
		cycle_limit = accesses.size() * 20 + n_trace * 12 * CLKS_PER_BIT;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk_cpu);
			if (i == 3) begin
				rst <= 1'b0;
			end
			@(negedge clk_cpu);
			expect_level("tx_o in reset", 1'b1, tx);
			expect_level("ack_o in reset", 1'b0, ack);
		end
		@(negedge clk_cpu);
		expect_level("tx_o after reset", 1'b1, tx);
		expect_level("ack_o after reset", 1'b0, ack);
		foreach (accesses[i]) begin
			run_access(accesses[i]);
			draw_gap(gap);
			repeat (gap) @(posedge clk_cpu);
		end
		// trace frames keep coming long after the last ack
		while (rx_count < n_trace) begin
			@(posedge clk_cpu);
		end
		// long enough for a stray extra frame to reach the decoder
		repeat (12 * CLKS_PER_BIT) @(posedge clk_cpu);
		if (stall_count == 0) begin
			$display("no fetch was held back by trace back-pressure");
			abort_run();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

	initial begin : serial_decoder
		trace_byte_t got;
		trace_byte_t want;
		rx_count = 0;
		wait (rst === 1'b0);
		forever begin
			@(negedge tx);
			// land in the middle of each bit
			repeat (CLKS_PER_BIT / 2) @(negedge clk_cpu);
			expect_level("tx_o start bit", 1'b0, tx);
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk_cpu);
				got[i] = tx;
			end
			repeat (CLKS_PER_BIT) @(negedge clk_cpu);
			expect_level("tx_o stop bit", 1'b1, tx);
			if (exp_bytes.size() == 0) begin
				$display("serial line sent a byte beyond the expected trace");
				abort_run();
			end
			want = exp_bytes.pop_front();
			compare_trace_byte($sformatf("tx_o byte %0d", rx_count), want, got);
			rx_count++;
		end
	end

	initial begin : watchdog
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk_cpu);
			cycles++;
		end
		$display("run timed out after %0d cycles", cycle_limit);
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

endmodule

// ==== src.f ====
rtl/soc_mem_pkg.sv
rtl/mem_router.sv
rtl/inst_rom.sv
rtl/data_ram.sv
rtl/fetch_tracer.sv
rtl/sync_fifo.sv
rtl/uart_tx.sv
rtl/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// ==== rtl/inst_rom.hex ====
00000093
10000113
00112023
00012183
00108093
fe209ce3
004182b3
40520333
0062f3b3
0073e433
00841493
0014d513
00a50023
00054583
0000006f
00000013

// ==== dv/mem_golden.txt ====
// columns: op (0 read, 1 write, 3 trace, f end) _ addr _ wdata _ strb _ rdata _ err
// trace rows carry four serial bytes in the rdata column, first sent on the left
0_00000000_00000000_0_00000093_0
0_00000004_00000000_0_10000113_0
1_00000040_deadbeef_f_00000000_0
0_00000040_00000000_0_deadbeef_0
0_00000044_00000000_0_00000000_0
1_00000044_000000a5_1_00000000_0
0_00000044_00000000_0_000000a5_0
1_00000040_12345678_c_00000000_0
1_00000040_0000aa00_2_00000000_0
0_00000040_00000000_0_1234aaef_0
1_00000008_ffffffff_f_00000000_1
0_00000140_00000000_0_00000000_1
0_00000008_00000000_0_00112023_0
0_0000000c_00000000_0_00012183_0
0_00000010_00000000_0_00108093_0
0_00000014_00000000_0_fe209ce3_0
0_00000018_00000000_0_004182b3_0
0_0000001c_00000000_0_40520333_0
3_00000000_00000000_0_93000000_0
3_00000000_00000000_0_13010010_0
3_00000000_00000000_0_23201100_0
3_00000000_00000000_0_83210100_0
3_00000000_00000000_0_93801000_0
3_00000000_00000000_0_e39c20fe_0
3_00000000_00000000_0_b3824100_0
3_00000000_00000000_0_33035240_0
f_00000000_00000000_0_00000000_0
